/* lz_window_top.f */
design/lz_pkg.sv
design/bank_ram.sv
design/unaligned_mem.sv
design/window_buffer.sv
design/match_scorer.sv
design/lz_window_top.sv
testbench/tb_lz_window.sv

/* run_sim.sh */
#!/bin/sh
# build and run the window testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing -j 0 \
    --top-module tb_lz_window \
    -f lz_window_top.f \
    -o tb_lz_window

./obj_dir/tb_lz_window

/* testbench/tb_lz_window.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_lz_window;

    localparam int SIZE_LOG2 = 6;
    localparam int S = 2**SIZE_LOG2;
    localparam int W = lz_pkg::MATCH_PE_WIDTH;
    localparam int NBPIPE = 3;
    localparam int DRAIN_LIMIT = 32;

    typedef enum logic [1:0] {KIND_IDLE, KIND_WRITE, KIND_READ} kind_t;

    typedef struct packed {
        kind_t kind;
        logic [31:0] address;
        logic [3:0] count;
    } stim_t;

    typedef struct packed {
        logic [31:0] due;
        logic unsafe;
        logic data_known;
        logic [lz_pkg::MATCH_PE_WIDTH_LOG2:0] length;
        lz_pkg::byte_vec_t data;
    } exp_t;

    logic clk;
    logic rst_n;
    lz_pkg::wr_req_t wr;
    lz_pkg::rd_req_t rd;
    lz_pkg::match_result_t result;

    stim_t stim_q[$];
    exp_t exp_q[$];
    logic [31:0] edge_count = '0;
    logic [31:0] rng = 32'hc00d11e2;

    // reference window, indexed by address modulo S
    logic [7:0] mem_model [S];
    logic written [S];
    logic m_filling;
    logic m_two_range;
    int m_cur_hi;
    int m_prev_hi;
    int m_last_lo;

    lz_window_top #(
        .SIZE_BYTES_LOG2(SIZE_LOG2),
        .NBPIPE(NBPIPE)
    ) dut0 (
        .clk(clk),
        .rst_n(rst_n),
        .wr(wr),
        .rd(rd),
        .result(result)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    always @(posedge clk) begin
        edge_count <= edge_count + 1;
    end

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    function automatic lz_pkg::byte_vec_t next_data();
        lz_pkg::byte_vec_t v;
        rng = xorshift32(rng);
        v[31:0] = rng;
        rng = xorshift32(rng);
        v[63:32] = rng;
        return v;
    endfunction

    function automatic lz_pkg::byte_vec_t model_bytes(input int addr);
        lz_pkg::byte_vec_t v;
        logic [SIZE_LOG2-1:0] idx;
        v = '0;
        idx = SIZE_LOG2'(addr);
        for (int i = 0; i < W; i++) begin
            v = {mem_model[idx], v[63:8]};
            idx = idx + 1'b1;
        end
        return v;
    endfunction

    function automatic logic bytes_written(input int addr);
        logic all_set;
        logic [SIZE_LOG2-1:0] idx;
        all_set = 1'b1;
        idx = SIZE_LOG2'(addr);
        for (int i = 0; i < W; i++) begin
            all_set = all_set & written[idx];
            idx = idx + 1'b1;
        end
        return all_set;
    endfunction

    // first count bytes match, the byte after them is inverted
    function automatic lz_pkg::byte_vec_t make_lookahead(input lz_pkg::byte_vec_t d, input int count);
        lz_pkg::byte_vec_t la;
        lz_pkg::byte_vec_t x;
        logic [7:0] b;
        la = '0;
        x = d;
        for (int i = 0; i < W; i++) begin
            b = x[7:0];
            if (i == count) begin
                b = ~b;
            end
            la = {b, la[63:8]};
            x = x >> 8;
        end
        return la;
    endfunction

    function automatic logic [3:0] leading_match(input lz_pkg::byte_vec_t a,
                                                 input lz_pkg::byte_vec_t b);
        logic [3:0] n;
        lz_pkg::byte_vec_t x;
        lz_pkg::byte_vec_t y;
        n = '0;
        x = a;
        y = b;
        for (int i = 0; i < W; i++) begin
            if (x[7:0] != y[7:0]) begin
                break;
            end
            n = n + 4'd1;
            x = x >> 8;
            y = y >> 8;
        end
        return n;
    endfunction

    function automatic logic read_is_unsafe(input int addr);
        int lo;
        int cur_end;
        logic safe;
        lo = addr % S;
        // a read across the top of the window is never safe
        if (lo > S - W) begin
            return 1'b1;
        end
        cur_end = (m_filling || m_two_range) ? m_last_lo : S - W;
        safe = (addr >= m_cur_hi * S) && (addr <= m_cur_hi * S + cur_end);
        if (m_two_range && addr >= m_prev_hi * S + m_last_lo + W &&
            addr <= m_prev_hi * S + S - W) begin
            safe = 1'b1;
        end
        return !safe;
    endfunction

    task automatic model_write(input int addr, input lz_pkg::byte_vec_t d);
        lz_pkg::byte_vec_t x;
        logic [SIZE_LOG2-1:0] idx;
        int lo;
        x = d;
        idx = SIZE_LOG2'(addr);
        lo = addr % S;
        for (int i = 0; i < W; i++) begin
            mem_model[idx] = x[7:0];
            written[idx] = 1'b1;
            x = x >> 8;
            idx = idx + 1'b1;
        end
        if (lo == 0 && !m_filling) begin
            m_two_range = 1'b1;
            m_prev_hi = m_cur_hi;
            m_cur_hi = addr / S;
        end else if (lo == S - W) begin
            m_two_range = 1'b0;
            m_filling = 1'b0;
        end
        m_last_lo = lo;
    endtask

    task automatic compare_value(input logic [63:0] got, input logic [63:0] expected,
                                 input string what);
        if (got !== expected) begin
            $display("FAIL %0t: %s is %h, expected %h", $time, what, got, expected);
            $display("Finished with errors");
            $fatal(1, "output mismatch");
        end
    endtask

    task automatic put_entry(input kind_t kind, input int address, input int count);
        stim_t s;
        s.kind = kind;
        s.address = 32'(address);
        s.count = 4'(count);
        stim_q.push_back(s);
    endtask

    task automatic build_table();
        repeat (3) put_entry(KIND_IDLE, 0, 0);
        // first lap, partly filled
        for (int a = 0; a <= 32; a += 8) begin
            put_entry(KIND_WRITE, a, 0);
        end
        put_entry(KIND_READ, 0, 8);
        put_entry(KIND_READ, 5, 3);
        put_entry(KIND_READ, 32, 8);
        put_entry(KIND_READ, 31, 1);
        put_entry(KIND_READ, 33, 8);
        put_entry(KIND_READ, 40, 0);
        for (int a = 40; a <= 56; a += 8) begin
            put_entry(KIND_WRITE, a, 0);
        end
        put_entry(KIND_READ, 56, 8);
        put_entry(KIND_READ, 57, 2);
        put_entry(KIND_READ, 63, 8);
        // second lap opens the old-lap range
        put_entry(KIND_WRITE, 64, 0);
        put_entry(KIND_WRITE, 72, 0);
        put_entry(KIND_READ, 16, 8);
        put_entry(KIND_READ, 20, 4);
        put_entry(KIND_READ, 56, 7);
        put_entry(KIND_READ, 8, 8);
        put_entry(KIND_READ, 15, 8);
        put_entry(KIND_READ, 70, 8);
        put_entry(KIND_READ, 73, 8);
        put_entry(KIND_READ, 61, 8);
        for (int c = 0; c <= W; c++) begin
            put_entry(KIND_READ, 66, c);
        end
        // reads and writes interleaved
        put_entry(KIND_WRITE, 80, 0);
        put_entry(KIND_READ, 24, 3);
        put_entry(KIND_WRITE, 88, 0);
        put_entry(KIND_READ, 80, 5);
        put_entry(KIND_READ, 33, 8);
        put_entry(KIND_WRITE, 96, 0);
        put_entry(KIND_READ, 95, 2);
        put_entry(KIND_READ, 36, 4);
        put_entry(KIND_READ, 40, 6);
        // last block of the lap, back to one range
        for (int a = 104; a <= 120; a += 8) begin
            put_entry(KIND_WRITE, a, 0);
        end
        put_entry(KIND_READ, 40, 8);
        put_entry(KIND_READ, 56, 8);
        put_entry(KIND_READ, 64, 8);
        put_entry(KIND_READ, 100, 5);
        put_entry(KIND_READ, 120, 8);
        put_entry(KIND_READ, 121, 8);
        put_entry(KIND_READ, 8, 8);
    endtask

    task automatic apply_entry(input stim_t s);
        lz_pkg::byte_vec_t d;
        lz_pkg::byte_vec_t la;
        exp_t e;
        wr = '0;
        rd = '0;
        case (s.kind)
            KIND_WRITE: begin
                d = next_data();
                wr.enable = 1'b1;
                wr.address = s.address;
                wr.data = d;
                model_write(int'(s.address), d);
            end
            KIND_READ: begin
                e.data = model_bytes(int'(s.address));
                e.data_known = bytes_written(int'(s.address));
                la = make_lookahead(e.data, int'(s.count));
                e.unsafe = read_is_unsafe(int'(s.address));
                e.length = e.unsafe ? 4'd0 : leading_match(e.data, la);
                e.due = edge_count + NBPIPE + 2;
                exp_q.push_back(e);
                rd.enable = 1'b1;
                rd.address = s.address;
                rd.lookahead = la;
            end
            default: begin
            end
        endcase
    endtask

    // valid must be high exactly when a read is due
    task automatic check_outputs();
        exp_t e;
        if (exp_q.size() > 0 && exp_q[0].due == edge_count) begin
            e = exp_q.pop_front();
            compare_value(64'(result.valid), 64'd1, "valid");
            compare_value(64'(result.unsafe), 64'(e.unsafe), "unsafe flag");
            compare_value(64'(result.length), 64'(e.length), "match length");
            if (e.data_known) begin
                compare_value(result.data, e.data, "read data");
            end
        end else begin
            compare_value(64'(result.valid), 64'd0, "valid with no read due");
        end
    endtask

    initial begin
        int waited;
        rst_n = 1'b0;
        wr = '0;
        rd = '0;
        m_filling = 1'b1;
        m_two_range = 1'b0;
        m_cur_hi = 0;
        m_prev_hi = 0;
        m_last_lo = 0;
        for (int i = 0; i < S; i++) begin
            mem_model[i] = 8'h00;
            written[i] = 1'b0;
        end
        build_table();
        for (int i = 0; i < 2; i++) begin
            @(negedge clk);
            check_outputs();
        end
        rst_n = 1'b1;
        foreach (stim_q[i]) begin
            apply_entry(stim_q[i]);
            @(negedge clk);
            check_outputs();
        end
        wr = '0;
        rd = '0;
        waited = 0;
        while (exp_q.size() > 0) begin
            if (waited == DRAIN_LIMIT) begin
                $display("timeout: read results still outstanding after the last request");
                $display("Finished with errors");
                $fatal(1, "drain timeout");
            end else begin
                @(negedge clk);
                check_outputs();
                waited++;
            end
        end
        $display("Finished with no errors");
        $finish;
    end

endmodule

`default_nettype wire

/* design/lz_window_top.sv */
`timescale 1ns/1ps
`default_nettype none

module lz_window_top #(
    parameter int SIZE_BYTES_LOG2 = 10,
    parameter int NBPIPE = 3
) (
    input wire clk,
    input wire rst_n,
    input wire lz_pkg::wr_req_t wr,
    input wire lz_pkg::rd_req_t rd,
    output lz_pkg::match_result_t result
);

    logic read_unsafe;
    lz_pkg::byte_vec_t read_data;
    lz_pkg::match_result_t score;

    window_buffer #(
        .SIZE_BYTES_LOG2(SIZE_BYTES_LOG2),
        .NBPIPE(NBPIPE)
    ) window_buffer_inst (
        .clk(clk),
        .rst_n(rst_n),
        .write_enable(wr.enable),
        .write_address(wr.address),
        .write_data(wr.data),
        .read_enable(rd.enable),
        .read_address(rd.address),
        .read_unsafe(read_unsafe),
        .read_data(read_data)
    );

    match_scorer #(
        .NBPIPE(NBPIPE)
    ) match_scorer_inst (
        .clk(clk),
        .rst_n(rst_n),
        .read_enable(rd.enable),
        .lookahead(rd.lookahead),
        .read_data(read_data),
        .read_unsafe(read_unsafe),
        .result(score)
    );

    // one stage per register on the read path
    logic [NBPIPE+1:0] valid_sr;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            valid_sr <= '0;
        end else begin
            valid_sr <= {valid_sr[NBPIPE:0], rd.enable};
        end
    end

    always_comb begin
        result = score;
        result.valid = valid_sr[NBPIPE+1];
    end

endmodule

`default_nettype wire

/* design/match_scorer.sv */
`timescale 1ns/1ps
`default_nettype none

module match_scorer #(
    parameter int NBPIPE = 3
) (
    input wire clk,
    input wire rst_n,
    input wire read_enable,
    input wire lz_pkg::byte_vec_t lookahead,
    input wire lz_pkg::byte_vec_t read_data,
    input wire read_unsafe,
    output lz_pkg::match_result_t result
);

    localparam int W = lz_pkg::MATCH_PE_WIDTH;
    localparam int LEN_W = lz_pkg::MATCH_PE_WIDTH_LOG2 + 1;

    // lookahead waits for the memory data
    lz_pkg::byte_vec_t la_pipe [NBPIPE+1];

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int i = 0; i <= NBPIPE; i++) begin
                la_pipe[i] <= '0;
            end
        end else begin
            if (read_enable) begin
                la_pipe[0] <= lookahead;
            end
            for (int i = 1; i <= NBPIPE; i++) begin
                la_pipe[i] <= la_pipe[i-1];
            end
        end
    end

    logic [LEN_W-1:0] match_len;

    // count equal bytes from byte 0 until the first mismatch
    always_comb begin
        logic run;
        run = 1'b1;
        match_len = '0;
        for (int i = 0; i < W; i++) begin
            if (run && (read_data[8*i +: 8] == la_pipe[NBPIPE][8*i +: 8])) begin
                match_len = match_len + 1'b1;
            end else begin
                run = 1'b0;
            end
        end
        if (read_unsafe) begin
            match_len = '0;
        end
    end

    logic unsafe_q;
    logic [LEN_W-1:0] length_q;
    lz_pkg::byte_vec_t data_q;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            unsafe_q <= 1'b0;
            length_q <= '0;
            data_q <= '0;
        end else begin
            unsafe_q <= read_unsafe;
            length_q <= match_len;
            data_q <= read_data;
        end
    end

    // valid is added by the top level
    assign result.valid = 1'b0;
    assign result.unsafe = unsafe_q;
    assign result.length = length_q;
    assign result.data = data_q;

endmodule

`default_nettype wire

/* design/window_buffer.sv */
`timescale 1ns/1ps
`default_nettype none

module window_buffer #(
    parameter int SIZE_BYTES_LOG2 = 10,
    parameter int NBPIPE = 3
) (
    input wire clk,
    input wire rst_n,
    input wire write_enable,
    input wire [lz_pkg::ADDR_WIDTH-1:0] write_address,
    input wire lz_pkg::byte_vec_t write_data,
    input wire read_enable,
    input wire [lz_pkg::ADDR_WIDTH-1:0] read_address,
    output logic read_unsafe,
    output lz_pkg::byte_vec_t read_data
);

    localparam int W = lz_pkg::MATCH_PE_WIDTH;
    localparam int W_LOG2 = lz_pkg::MATCH_PE_WIDTH_LOG2;
    localparam int LO_W = SIZE_BYTES_LOG2;
    localparam int HI_W = lz_pkg::ADDR_WIDTH - SIZE_BYTES_LOG2;

    // last aligned block of the window
    localparam logic [LO_W-1:0] TAIL_LO = LO_W'((2**LO_W) - W);

    logic [LO_W-1:0] write_lo;
    logic [HI_W-1:0] write_hi;

    assign write_lo = write_address[LO_W-1:0];
    assign write_hi = write_address[lz_pkg::ADDR_WIDTH-1:LO_W];

    logic filling;
    logic two_range;
    logic [HI_W-1:0] cur_hi;
    logic [HI_W-1:0] prev_hi;
    logic [LO_W-1:0] last_lo;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            filling <= 1'b1;
            two_range <= 1'b0;
            cur_hi <= '0;
            prev_hi <= '0;
            last_lo <= '0;
        end else if (write_enable) begin
            last_lo <= write_lo;
            if (write_lo == '0) begin
                // new lap, the old one becomes the second range
                if (!filling) begin
                    two_range <= 1'b1;
                    prev_hi <= cur_hi;
                    cur_hi <= write_hi;
                end
            end else if (write_lo == TAIL_LO) begin
                two_range <= 1'b0;
                filling <= 1'b0;
            end
        end
    end

    logic [LO_W-1:0] last_lo_next;
    logic [lz_pkg::ADDR_WIDTH-1:0] range0_start;
    logic [lz_pkg::ADDR_WIDTH-1:0] range0_end;
    logic [lz_pkg::ADDR_WIDTH-1:0] range1_start;
    logic [lz_pkg::ADDR_WIDTH-1:0] range1_end;
    logic in_range0;
    logic in_range1;
    logic unsafe_now;

    assign last_lo_next = last_lo + LO_W'(W);
    assign range0_start = {cur_hi, {LO_W{1'b0}}};
    assign range0_end = {cur_hi, (two_range || filling) ? last_lo : TAIL_LO};
    assign range1_start = {prev_hi, last_lo_next};
    assign range1_end = {prev_hi, TAIL_LO};

    // both ranges end at or below TAIL_LO, so reads across the wrap never match
    assign in_range0 = (read_address >= range0_start) && (read_address <= range0_end);
    assign in_range1 = (read_address >= range1_start) && (read_address <= range1_end);
    assign unsafe_now = !(in_range0 || (two_range && in_range1));

    // line up with the memory read latency
    logic [NBPIPE:0] unsafe_sr;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            unsafe_sr <= '0;
        end else begin
            unsafe_sr <= {unsafe_sr[NBPIPE-1:0], unsafe_now};
        end
    end

    assign read_unsafe = unsafe_sr[NBPIPE];

    logic [LO_W-1:0] aligned_write_lo;

    assign aligned_write_lo = {write_address[LO_W-1:W_LOG2], {W_LOG2{1'b0}}};

    unaligned_mem #(
        .SIZE_BYTES_LOG2(SIZE_BYTES_LOG2),
        .NBPIPE(NBPIPE)
    ) unaligned_mem_inst (
        .clk(clk),
        .rst_n(rst_n),
        .write_enable(write_enable),
        .write_address(aligned_write_lo),
        .write_data(write_data),
        .read_enable(read_enable),
        .read_address(read_address[LO_W-1:0]),
        .read_data(read_data)
    );

endmodule

`default_nettype wire

/* design/unaligned_mem.sv */
`timescale 1ns/1ps
`default_nettype none

module unaligned_mem #(
    parameter int SIZE_BYTES_LOG2 = 10,
    parameter int NBPIPE = 3
) (
    input wire clk,
    input wire rst_n,
    input wire write_enable,
    input wire [SIZE_BYTES_LOG2-1:0] write_address,
    input wire lz_pkg::byte_vec_t write_data,
    input wire read_enable,
    input wire [SIZE_BYTES_LOG2-1:0] read_address,
    output lz_pkg::byte_vec_t read_data
);

    localparam int W = lz_pkg::MATCH_PE_WIDTH;
    localparam int W_LOG2 = lz_pkg::MATCH_PE_WIDTH_LOG2;
    localparam int ROW_W = SIZE_BYTES_LOG2 - W_LOG2;

    logic [ROW_W-1:0] write_row;
    logic [ROW_W-1:0] read_row;
    logic [W_LOG2-1:0] read_offset;

    assign write_row = write_address[SIZE_BYTES_LOG2-1:W_LOG2];
    assign read_row = read_address[SIZE_BYTES_LOG2-1:W_LOG2];
    assign read_offset = read_address[W_LOG2-1:0];

    lz_pkg::byte_vec_t bank_data;

    genvar b;
    generate
        for (b = 0; b < W; b++) begin : g_bank
            logic [ROW_W-1:0] bank_row;

            // banks below the offset hold bytes from the next row, wraps at the top
            assign bank_row = read_row + ROW_W'(b < read_offset);

            bank_ram #(
                .SIZE_BYTES_LOG2(SIZE_BYTES_LOG2),
                .NBPIPE(NBPIPE)
            ) bank_ram_inst (
                .clk(clk),
                .write_enable(write_enable),
                .write_row(write_row),
                .write_byte(write_data[8*b +: 8]),
                .read_enable(read_enable),
                .read_row(bank_row),
                .read_byte(bank_data[8*b +: 8])
            );
        end
    endgenerate

    // offset follows the banks with the same latency
    logic [W_LOG2-1:0] offset_pipe [NBPIPE];

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int i = 0; i < NBPIPE; i++) begin
                offset_pipe[i] <= '0;
            end
        end else begin
            if (read_enable) begin
                offset_pipe[0] <= read_offset;
            end
            for (int i = 1; i < NBPIPE; i++) begin
                offset_pipe[i] <= offset_pipe[i-1];
            end
        end
    end

    lz_pkg::byte_vec_t rotated;

    // output byte i comes from bank (i + offset) mod W
    always_comb begin
        logic [W_LOG2-1:0] src;
        rotated = '0;
        for (int i = 0; i < W; i++) begin
            src = W_LOG2'(i) + offset_pipe[NBPIPE-1];
            rotated[8*i +: 8] = bank_data[8*src +: 8];
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            read_data <= '0;
        end else begin
            read_data <= rotated;
        end
    end

endmodule

`default_nettype wire

/* design/bank_ram.sv */
`timescale 1ns/1ps
`default_nettype none

module bank_ram #(
    parameter int SIZE_BYTES_LOG2 = 10,
    parameter int NBPIPE = 3
) (
    input wire clk,
    input wire write_enable,
    input wire [SIZE_BYTES_LOG2-lz_pkg::MATCH_PE_WIDTH_LOG2-1:0] write_row,
    input wire [7:0] write_byte,
    input wire read_enable,
    input wire [SIZE_BYTES_LOG2-lz_pkg::MATCH_PE_WIDTH_LOG2-1:0] read_row,
    output logic [7:0] read_byte
);

    localparam int ROW_W = SIZE_BYTES_LOG2 - lz_pkg::MATCH_PE_WIDTH_LOG2;
    localparam int ROWS = 2**ROW_W;

    // one byte lane of the window
    logic [7:0] mem [ROWS];

    // stage 0 is the array read, the rest only add latency
    logic [7:0] pipe [NBPIPE];

    always_ff @(posedge clk) begin
        if (write_enable) begin
            mem[write_row] <= write_byte;
        end
    end

    always_ff @(posedge clk) begin
        if (read_enable) begin
            pipe[0] <= mem[read_row];
        end
        for (int i = 1; i < NBPIPE; i++) begin
            pipe[i] <= pipe[i-1];
        end
    end

    assign read_byte = pipe[NBPIPE-1];

endmodule

`default_nettype wire

/* design/lz_pkg.sv */
`default_nettype none

package lz_pkg;

    // bytes per block write and per read
    localparam int MATCH_PE_WIDTH = 8;
    localparam int MATCH_PE_WIDTH_LOG2 = 3;

    // full stream byte address
    localparam int ADDR_WIDTH = 32;

    // byte 0 in the low bits, lowest address
    typedef logic [MATCH_PE_WIDTH*8-1:0] byte_vec_t;

    // address must be block aligned
    typedef struct packed {
        logic enable;
        logic [ADDR_WIDTH-1:0] address;
        byte_vec_t data;
    } wr_req_t;

    typedef struct packed {
        logic enable;
        logic [ADDR_WIDTH-1:0] address;
        byte_vec_t lookahead;
    } rd_req_t;

    // length counts 0..MATCH_PE_WIDTH
    typedef struct packed {
        logic valid;
        logic unsafe;
        logic [MATCH_PE_WIDTH_LOG2:0] length;
        byte_vec_t data;
    } match_result_t;

endpackage

`default_nettype wire
